//--- cmd_pipe.f
+incdir+testbench
design/pipe_pkg.sv
design/pipe_ctrl.sv
design/cmd_decode_stage.sv
design/cmd_exec_stage.sv
design/cmd_wb_stage.sv
design/cmd_pipe.sv
testbench/cmd_pipe_tb.sv

//--- run.sh
#!/bin/sh
# build the command pipeline testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
  -f cmd_pipe.f --top-module cmd_pipe_tb -o cmd_pipe_sim

out=$(./obj_dir/cmd_pipe_sim)
echo "$out"

# the status of this last search is the status of the script
echo "$out" | grep -q "^Testbench passed$"

//--- testbench/cmd_pipe_model.svh
// stimulus table row type, Galois LFSR step, shadow register file and result model
`ifndef CMD_PIPE_MODEL_SVH
`define CMD_PIPE_MODEL_SVH

// one table row, the expected half is filled in by the model
typedef struct packed {
  logic [3:0]        test_id;
  pipe_pkg::cmd_t    cmd;
  // out_stall comes from the LFSR while this row is presented
  logic              rand_stall;
  // low for a command squashed behind a SKIP
  logic              produces;
  pipe_pkg::result_t exp;
} stim_t;

localparam logic [15:0] LFSR_SEED = 16'd21;
// x^16 + x^14 + x^13 + x^11 + 1, right-shifting form
localparam logic [15:0] LFSR_TAPS = 16'hB400;

// shadow architectural registers
logic [pipe_pkg::DATA_W-1:0] shadow_regs [pipe_pkg::REG_N];
// set by a SKIP, cleared by the command it kills
logic drop_next;

function automatic logic [15:0] lfsr_next(input logic [15:0] s);
  if (s[0]) begin
    lfsr_next = (s >> 1) ^ LFSR_TAPS;
  end else begin
    lfsr_next = s >> 1;
  end
endfunction

// fills in the expected result of one accepted command, in acceptance order
function automatic stim_t model_entry(input stim_t e, input int tag);
  stim_t           r;
  longint unsigned a;
  longint unsigned imm;
  longint unsigned v;
  r = e;
  a = shadow_regs[e.cmd.rs];
  // immediates are unsigned
  imm = e.cmd.imm;
  v = 0;
  r.produces = 1'b0;
  r.exp = '0;
  if (drop_next) begin
    // emptied out of decode while the SKIP sat in execute
    drop_next = 1'b0;
  end else begin
    case (e.cmd.op)
      pipe_pkg::OP_ADD: v = a + imm;
      pipe_pkg::OP_SUB: v = a - imm;
      pipe_pkg::OP_MUL: v = a * imm;
      default: begin
        // SKIP still reaches the output, carrying zero
        v = 0;
        drop_next = 1'b1;
      end
    endcase
    r.produces = 1'b1;
    r.exp.tag = pipe_pkg::TAG_W'(tag);
    r.exp.rd = e.cmd.rd;
    // results wrap at 16 bits
    r.exp.value = v[pipe_pkg::DATA_W-1:0];
    if (e.cmd.op != pipe_pkg::OP_SKIP) begin
      shadow_regs[e.cmd.rd] = r.exp.value;
    end
  end
  model_entry = r;
endfunction

`endif

//--- testbench/cmd_pipe_tb.sv
// testbench for cmd_pipe: clock, reset, table-driven stimulus, output checker, watchdog
module cmd_pipe_tb;
  timeunit 1ns;
  timeprecision 1ns;

  localparam int CLK_PERIOD   = 100;
  localparam int RST_CYCLES   = 8;
  localparam int MUL_CYCLES   = 3;
  localparam int TBL_LEN      = 30;
  localparam int N_TESTS      = 5;
  // idle cycles at the end that must stay free of outputs
  localparam int DRAIN_CYCLES = 8;

  logic              clk = 1'b0;
  logic              rst;
  logic              in_val;
  pipe_pkg::cmd_t    in_cmd;
  logic              in_stall;
  logic              out_val;
  pipe_pkg::result_t out_data;
  logic              out_stall;

  `include "cmd_pipe_model.svh"

  // stimulus and expected results, one row per command
  stim_t       stim_tbl [TBL_LEN];
  string       test_names [N_TESTS];
  // last producing row, result count and mismatches per test
  int          last_idx [N_TESTS];
  int          n_results [N_TESTS];
  int          n_wrong [N_TESTS];
  int          n_fill;
  // row on in_cmd, and next row expected on out_data
  int          drv_idx;
  int          chk_idx;
  int          n_checked;
  int          n_errors;
  logic [15:0] lfsr_state;

  cmd_pipe #(.mul_cycles(MUL_CYCLES)) DUT (
    .clk       (clk),
    .rst       (rst),
    .in_val    (in_val),
    .in_cmd    (in_cmd),
    .in_stall  (in_stall),
    .out_val   (out_val),
    .out_data  (out_data),
    .out_stall (out_stall)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // --------------------------------------------------
  // table
  // --------------------------------------------------

  task automatic add_entry(input int test_id, input pipe_pkg::op_e op, input int rd,
                           input int rs, input int imm, input logic rnd);
    stim_tbl[n_fill] = '0;
    stim_tbl[n_fill].test_id = 4'(test_id);
    stim_tbl[n_fill].cmd.op = op;
    stim_tbl[n_fill].cmd.rd = pipe_pkg::REG_AW'(rd);
    stim_tbl[n_fill].cmd.rs = pipe_pkg::REG_AW'(rs);
    stim_tbl[n_fill].cmd.imm = pipe_pkg::IMM_W'(imm);
    stim_tbl[n_fill].rand_stall = rnd;
    n_fill++;
  endtask

  task automatic fill_table();
    n_fill = 0;
    test_names[0] = "reset_add";
    test_names[1] = "bypass_chain";
    test_names[2] = "mul_order";
    test_names[3] = "skip_drop";
    test_names[4] = "random_stall";
    // fresh registers read as zero
    add_entry(0, pipe_pkg::OP_ADD, 1, 0, 5, 1'b0);
    add_entry(0, pipe_pkg::OP_ADD, 2, 0, 127, 1'b0);
    add_entry(0, pipe_pkg::OP_ADD, 3, 0, 255, 1'b0);
    add_entry(0, pipe_pkg::OP_ADD, 0, 0, 3, 1'b0);
    // each rs is the rd just before it, SUB wraps below zero
    add_entry(1, pipe_pkg::OP_ADD, 1, 1, 1, 1'b0);
    add_entry(1, pipe_pkg::OP_SUB, 2, 1, 2, 1'b0);
    add_entry(1, pipe_pkg::OP_ADD, 3, 2, 10, 1'b0);
    add_entry(1, pipe_pkg::OP_SUB, 1, 3, 20, 1'b0);
    add_entry(1, pipe_pkg::OP_ADD, 2, 1, 6, 1'b0);
    // second MUL overflows 16 bits
    add_entry(2, pipe_pkg::OP_MUL, 1, 3, 200, 1'b0);
    add_entry(2, pipe_pkg::OP_MUL, 2, 1, 255, 1'b0);
    add_entry(2, pipe_pkg::OP_ADD, 0, 2, 1, 1'b0);
    add_entry(2, pipe_pkg::OP_SUB, 3, 0, 4, 1'b0);
    // the ADD to r3 is dropped, the next row reads r3 back
    add_entry(3, pipe_pkg::OP_SKIP, 0, 0, 0, 1'b0);
    add_entry(3, pipe_pkg::OP_ADD, 3, 3, 99, 1'b0);
    add_entry(3, pipe_pkg::OP_ADD, 0, 3, 0, 1'b0);
    // a dropped SKIP drops nothing
    add_entry(3, pipe_pkg::OP_SKIP, 0, 0, 0, 1'b0);
    add_entry(3, pipe_pkg::OP_SKIP, 0, 0, 0, 1'b0);
    add_entry(3, pipe_pkg::OP_ADD, 1, 1, 1, 1'b0);
    add_entry(4, pipe_pkg::OP_ADD, 1, 0, 17, 1'b1);
    add_entry(4, pipe_pkg::OP_MUL, 2, 1, 33, 1'b1);
    add_entry(4, pipe_pkg::OP_SKIP, 0, 0, 0, 1'b1);
    add_entry(4, pipe_pkg::OP_SUB, 2, 2, 200, 1'b1);
    add_entry(4, pipe_pkg::OP_SUB, 3, 2, 7, 1'b1);
    add_entry(4, pipe_pkg::OP_MUL, 0, 3, 250, 1'b1);
    add_entry(4, pipe_pkg::OP_ADD, 1, 0, 1, 1'b1);
    add_entry(4, pipe_pkg::OP_SKIP, 2, 0, 0, 1'b1);
    add_entry(4, pipe_pkg::OP_MUL, 1, 1, 2, 1'b1);
    add_entry(4, pipe_pkg::OP_MUL, 3, 1, 9, 1'b1);
    add_entry(4, pipe_pkg::OP_ADD, 0, 3, 255, 1'b1);
  endtask

  task automatic build_expected();
    for (int r = 0; r < pipe_pkg::REG_N; r++) begin
      shadow_regs[r] = '0;
    end
    drop_next = 1'b0;
    for (int t = 0; t < N_TESTS; t++) begin
      last_idx[t] = -1;
      n_results[t] = 0;
      n_wrong[t] = 0;
    end
    // every row is accepted once and in order, so row i carries tag i
    for (int i = 0; i < TBL_LEN; i++) begin
      stim_tbl[i] = model_entry(stim_tbl[i], i);
      if (stim_tbl[i].produces) begin
        last_idx[stim_tbl[i].test_id] = i;
        n_results[stim_tbl[i].test_id]++;
      end
    end
  endtask

  function automatic int next_producing(input int idx);
    int i;
    i = idx;
    while (i < TBL_LEN && !stim_tbl[i].produces) begin
      i++;
    end
    next_producing = i;
  endfunction

  // --------------------------------------------------
  // stall source and checker
  // --------------------------------------------------

  // one LFSR step per bit, only while a random row is presented
  function automatic logic next_out_stall();
    int idx;
    idx = (drv_idx < TBL_LEN) ? drv_idx : TBL_LEN - 1;
    next_out_stall = 1'b0;
    if (stim_tbl[idx].rand_stall) begin
      lfsr_state = lfsr_next(lfsr_state);
      next_out_stall = lfsr_state[0];
    end
  endfunction

  task automatic report_test(input int t);
    if (n_wrong[t] == 0) begin
      $display("PASS %s, %0d results", test_names[t], n_results[t]);
    end else begin
      $display("FAIL %s, %0d of %0d results wrong", test_names[t], n_wrong[t], n_results[t]);
    end
  endtask

  task automatic check_output();
    int t;
    if (chk_idx >= TBL_LEN) begin
      $display("an output appeared after the last expected result, tag %0d", out_data.tag);
      n_errors++;
    end else begin
      t = stim_tbl[chk_idx].test_id;
      n_checked++;
      if (out_data !== stim_tbl[chk_idx].exp) begin
        $display("FAIL %s: expected tag %0d rd %0d value %h, actual tag %0d rd %0d value %h",
                 test_names[t], stim_tbl[chk_idx].exp.tag, stim_tbl[chk_idx].exp.rd,
                 stim_tbl[chk_idx].exp.value, out_data.tag, out_data.rd, out_data.value);
        n_wrong[t]++;
        n_errors++;
      end
      if (chk_idx == last_idx[t]) begin
        report_test(t);
      end
      chk_idx = next_producing(chk_idx + 1);
    end
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------

  initial begin : run
    int n_pass;
    rst = 1'b1;
    in_val = 1'b0;
    in_cmd = '0;
    out_stall = 1'b0;
    lfsr_state = LFSR_SEED;
    n_errors = 0;
    n_checked = 0;
    drv_idx = 0;
    fill_table();
    if (n_fill != TBL_LEN) begin
      $display("stimulus table holds %0d rows instead of %0d", n_fill, TBL_LEN);
      n_errors++;
    end
    build_expected();
    chk_idx = next_producing(0);
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    #(CLK_PERIOD / 4);
    if (out_val || in_stall) begin
      $display("out_val or in_stall is high right after reset");
      n_errors++;
    end
    // inputs move on the falling edge, everything is sampled a quarter period later
    while (drv_idx < TBL_LEN || chk_idx < TBL_LEN) begin
      @(negedge clk);
      in_val = (drv_idx < TBL_LEN);
      if (in_val) begin
        in_cmd = stim_tbl[drv_idx].cmd;
      end
      out_stall = next_out_stall();
      #(CLK_PERIOD / 4);
      if (in_val && !in_stall) begin
        drv_idx++;
      end
      if (out_val && !out_stall) begin
        check_output();
      end
    end
    // nothing further may come out
    repeat (DRAIN_CYCLES) begin
      @(negedge clk);
      in_val = 1'b0;
      out_stall = 1'b0;
      #(CLK_PERIOD / 4);
      if (out_val) begin
        check_output();
      end
    end
    n_pass = 0;
    for (int t = 0; t < N_TESTS; t++) begin
      if (n_wrong[t] == 0) begin
        n_pass++;
      end
    end
    $display("tests %0d, passed %0d, failed %0d, results checked %0d, errors %0d",
             N_TESTS, n_pass, N_TESTS - n_pass, n_checked, n_errors);
    if (n_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // worst case per row is a full MUL plus a few stalled cycles in each stage
  initial begin : watchdog
    #(TBL_LEN * (MUL_CYCLES + 4) * 4 * CLK_PERIOD);
    $display("the run did not finish within %0d clock periods",
             TBL_LEN * (MUL_CYCLES + 4) * 4);
    $display("Testbench failed");
    $finish;
  end

endmodule

//--- design/cmd_pipe.sv
// top level of the command pipeline: three stage controllers and the stage logic
module cmd_pipe #(
  parameter int mul_cycles = 3
) (
  input  logic              clk,
  input  logic              rst,

  // command input
  input  logic              in_val,
  input  pipe_pkg::cmd_t    in_cmd,
  output logic              in_stall,

  // result output
  output logic              out_val,
  output pipe_pkg::result_t out_data,
  input  logic              out_stall
);

  // decode stage
  pipe_pkg::cmd_t              dcd_cmd;
  pipe_pkg::dec_t              dcd_out;
  logic                        dcd_next_val;

  // execute stage
  pipe_pkg::dec_t              ex_payload;
  pipe_pkg::wb_t               ex_out;
  logic                        ex_prev_stall;
  logic                        ex_prev_squash;
  logic                        ex_val;
  logic                        ex_stall;
  logic                        ex_squash;
  logic                        ex_next_val;

  // writeback stage
  pipe_pkg::wb_t               wb_payload;
  logic                        wb_prev_stall;
  logic                        wb_prev_squash;

  // bypass read port
  logic [pipe_pkg::REG_AW-1:0] rs_sel;
  logic [pipe_pkg::DATA_W-1:0] rs_value;

  // --------------------------------------------------
  // decode
  // --------------------------------------------------

  // prev_squash has no consumer, the source never drops a command
  pipe_ctrl #(.payload_t(pipe_pkg::cmd_t)) u_dcd_ctrl (
    .clk         (clk),
    .rst         (rst),
    .prev_val    (in_val),
    .prev_stall  (in_stall),
    .prev_squash (),
    .curr_reg_en (),
    .curr_val    (),
    .curr_stall  (1'b0),
    .curr_squash (1'b0),
    .next_val    (dcd_next_val),
    .next_stall  (ex_prev_stall),
    .next_squash (ex_prev_squash),
    .d_payload   (in_cmd),
    .q_payload   (dcd_cmd)
  );

  cmd_decode_stage u_dcd (
    .clk      (clk),
    .rst      (rst),
    .in_val   (in_val),
    .in_stall (in_stall),
    .in_cmd   (dcd_cmd),
    .dec      (dcd_out)
  );

  // --------------------------------------------------
  // execute
  // --------------------------------------------------

  pipe_ctrl #(.payload_t(pipe_pkg::dec_t)) u_ex_ctrl (
    .clk         (clk),
    .rst         (rst),
    .prev_val    (dcd_next_val),
    .prev_stall  (ex_prev_stall),
    .prev_squash (ex_prev_squash),
    .curr_reg_en (),
    .curr_val    (ex_val),
    .curr_stall  (ex_stall),
    .curr_squash (ex_squash),
    .next_val    (ex_next_val),
    .next_stall  (wb_prev_stall),
    .next_squash (wb_prev_squash),
    .d_payload   (dcd_out),
    .q_payload   (ex_payload)
  );

  cmd_exec_stage #(.mul_cycles(mul_cycles)) u_ex (
    .clk         (clk),
    .rst         (rst),
    .curr_val    (ex_val),
    .ex          (ex_payload),
    .rs_sel      (rs_sel),
    .rs_value    (rs_value),
    .next_stall  (wb_prev_stall),
    .curr_stall  (ex_stall),
    .curr_squash (ex_squash),
    .wb          (ex_out)
  );

  // --------------------------------------------------
  // writeback
  // --------------------------------------------------

  // last stage, only out_stall holds it and nothing squashes it
  pipe_ctrl #(.payload_t(pipe_pkg::wb_t)) u_wb_ctrl (
    .clk         (clk),
    .rst         (rst),
    .prev_val    (ex_next_val),
    .prev_stall  (wb_prev_stall),
    .prev_squash (wb_prev_squash),
    .curr_reg_en (),
    .curr_val    (out_val),
    .curr_stall  (1'b0),
    .curr_squash (1'b0),
    .next_val    (),
    .next_stall  (out_stall),
    .next_squash (1'b0),
    .d_payload   (ex_out),
    .q_payload   (wb_payload)
  );

  cmd_wb_stage u_wb (
    .clk       (clk),
    .rst       (rst),
    .curr_val  (out_val),
    .wbp       (wb_payload),
    .out_stall (out_stall),
    .rs_sel    (rs_sel),
    .rs_value  (rs_value),
    .out_data  (out_data)
  );

endmodule

//--- design/cmd_wb_stage.sv
// writeback stage logic: register file, bypassed read port, result output
module cmd_wb_stage (
  input  logic                        clk,
  input  logic                        rst,

  // item held in the writeback stage register
  input  logic                        curr_val,
  input  pipe_pkg::wb_t               wbp,

  // output back-pressure
  input  logic                        out_stall,

  // read port for execute
  input  logic [pipe_pkg::REG_AW-1:0] rs_sel,
  output logic [pipe_pkg::DATA_W-1:0] rs_value,

  // result for out_data
  output pipe_pkg::result_t           out_data
);

  // architectural registers
  logic [pipe_pkg::DATA_W-1:0] regs [pipe_pkg::REG_N];
  // writeback commits this cycle
  logic                        wr_en;
  // execute reads the register writeback is about to update
  logic                        byp_hit;

  // --------------------------------------------------
  // register file
  // --------------------------------------------------

  // commit only when the result is actually taken downstream
  assign wr_en = curr_val && wbp.writes && !out_stall;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < pipe_pkg::REG_N; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wbp.rd] <= wbp.value;
    end
  end

  // --------------------------------------------------
  // bypass read
  // --------------------------------------------------

  // pending value wins over the file, stalled or not
  assign byp_hit = curr_val && wbp.writes && (wbp.rd == rs_sel);

  assign rs_value = byp_hit ? wbp.value : regs[rs_sel];

  // --------------------------------------------------
  // output
  // --------------------------------------------------

  assign out_data.tag   = wbp.tag;
  assign out_data.rd    = wbp.rd;
  assign out_data.value = wbp.value;

  // --------------------------------------------------
  // checks
  // --------------------------------------------------

  // the stage register must hold the result while the sink stalls
  a_out_hold: assert property (
    @(posedge clk) disable iff (rst)
    (curr_val && out_stall) |=> (curr_val && $stable(out_data))
  );

endmodule

//--- design/cmd_exec_stage.sv
// execute stage logic: ADD/SUB/MUL datapath, MUL stall counter, SKIP squash
module cmd_exec_stage #(
  parameter int mul_cycles = 3
) (
  input  logic                        clk,
  input  logic                        rst,

  // item held in the execute stage register
  input  logic                        curr_val,
  input  pipe_pkg::dec_t              ex,

  // operand read through the writeback bypass
  output logic [pipe_pkg::REG_AW-1:0] rs_sel,
  input  logic [pipe_pkg::DATA_W-1:0] rs_value,

  // controller hooks
  input  logic                        next_stall,
  output logic                        curr_stall,
  output logic                        curr_squash,

  // payload for the writeback stage register
  output pipe_pkg::wb_t               wb
);

  // counter wide enough to hold mul_cycles itself
  localparam int CNT_W = $clog2(mul_cycles + 1);
  // last counter value of a MUL, the cycle it may leave
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(mul_cycles - 1);

  // cycles spent so far by the current MUL
  logic [CNT_W-1:0]            mul_cnt;
  // valid MUL sitting in execute
  logic                        mul_busy;
  // full product before truncation
  logic [2*pipe_pkg::DATA_W-1:0] mul_full;
  // result for the current op
  logic [pipe_pkg::DATA_W-1:0] alu_res;

  // --------------------------------------------------
  // operand and datapath
  // --------------------------------------------------

  assign rs_sel = ex.rs;

  assign mul_full = rs_value * ex.imm;

  always_comb begin
    case (ex.op)
      pipe_pkg::OP_ADD: alu_res = rs_value + ex.imm;
      pipe_pkg::OP_SUB: alu_res = rs_value - ex.imm;
      // low half of the product only
      pipe_pkg::OP_MUL: alu_res = mul_full[pipe_pkg::DATA_W-1:0];
      // SKIP carries zero and never writes
      default:          alu_res = '0;
    endcase
  end

  assign wb.rd     = ex.rd;
  assign wb.value  = alu_res;
  assign wb.writes = ex.writes;
  assign wb.tag    = ex.tag;

  // --------------------------------------------------
  // multi-cycle MUL
  // --------------------------------------------------

  assign mul_busy = curr_val && (ex.op == pipe_pkg::OP_MUL);

  // hold for the first mul_cycles-1 cycles,
  // the product is taken on the last one
  assign curr_stall = mul_busy && (mul_cnt != CNT_LAST);

  always_ff @(posedge clk) begin
    if (rst) begin
      mul_cnt <= '0;
    end else if (curr_stall) begin
      mul_cnt <= mul_cnt + CNT_W'(1);
    end else if (curr_val && !next_stall) begin
      // item leaves, the next arrival starts from zero
      mul_cnt <= '0;
    end
  end

  // --------------------------------------------------
  // SKIP
  // --------------------------------------------------

  // the controller forwards this only once execute can move
  assign curr_squash = curr_val && (ex.op == pipe_pkg::OP_SKIP);

  // --------------------------------------------------
  // checks
  // --------------------------------------------------

  // a MUL held downstream must not keep counting
  a_mul_cnt_range: assert property (
    @(posedge clk) disable iff (rst)
    mul_cnt < CNT_W'(mul_cycles)
  );

endmodule

//--- design/cmd_decode_stage.sv
// decode stage logic: immediate widening, write flag and sequence tag counter
module cmd_decode_stage (
  input  logic           clk,
  input  logic           rst,

  // top-level input handshake, used to count accepted commands
  input  logic           in_val,
  input  logic           in_stall,

  // command held in the decode stage register
  input  pipe_pkg::cmd_t in_cmd,

  // payload for the execute stage register
  output pipe_pkg::dec_t dec
);

  // number of commands accepted so far
  logic [pipe_pkg::TAG_W-1:0] tag_cnt;
  // a command enters decode on this edge
  logic                       accept;

  // --------------------------------------------------
  // tag counter
  // --------------------------------------------------

  // same condition that loads the decode stage register
  assign accept = in_val && !in_stall;

  // squashed commands still consume a tag,
  // which leaves a visible gap in the output
  always_ff @(posedge clk) begin
    if (rst) begin
      tag_cnt <= '0;
    end else if (accept) begin
      tag_cnt <= tag_cnt + pipe_pkg::TAG_W'(1);
    end
  end

  // --------------------------------------------------
  // field mapping
  // --------------------------------------------------

  assign dec.op = in_cmd.op;
  assign dec.rd = in_cmd.rd;
  assign dec.rs = in_cmd.rs;

  // immediates are unsigned
  assign dec.imm = pipe_pkg::DATA_W'(in_cmd.imm);

  // the held command is always the last one accepted,
  // so its tag is one behind the counter
  assign dec.tag = tag_cnt - pipe_pkg::TAG_W'(1);

  // every op but SKIP updates rd
  assign dec.writes = (in_cmd.op != pipe_pkg::OP_SKIP);

endmodule

//--- design/pipe_ctrl.sv
// pipeline stage controller with valid bit, payload register and stall and squash aggregation
module pipe_ctrl #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,

  // towards the previous stage
  input  logic     prev_val,
  output logic     prev_stall,
  output logic     prev_squash,

  // this stage
  output logic     curr_reg_en,
  output logic     curr_val,
  input  logic     curr_stall,
  input  logic     curr_squash,

  // towards the next stage
  output logic     next_val,
  input  logic     next_stall,
  input  logic     next_squash,

  // stage payload
  input  payload_t d_payload,
  output payload_t q_payload
);

  // valid register enable
  logic val_en;

  // --------------------------------------------------
  // valid bit and payload register
  // --------------------------------------------------

  // load on a squash from downstream, or whenever upstream is not held
  assign val_en = !prev_stall || next_squash;

  // payload only moves when a real item comes in, or on a squash
  assign curr_reg_en = (!prev_stall && prev_val) || next_squash;

  always_ff @(posedge clk) begin
    if (rst) begin
      curr_val <= 1'b0;
    end else if (val_en) begin
      curr_val <= prev_val;
    end
  end

  always_ff @(posedge clk) begin
    if (curr_reg_en) begin
      q_payload <= d_payload;
    end
  end

  // --------------------------------------------------
  // handoff and aggregation
  // --------------------------------------------------

  // the item leaves only if nothing holds or kills it
  assign next_val = curr_val && !next_squash && !next_stall && !curr_stall;

  // a bubble never stalls upstream
  assign prev_stall = (next_stall || curr_stall) && curr_val;

  // own squash goes up only once this stage is free to move,
  // otherwise the same squash would fire on several cycles
  assign prev_squash = next_squash || (curr_squash && !next_stall && !curr_stall);

  // --------------------------------------------------
  // checks
  // --------------------------------------------------

  // a stage being emptied must not hold back the one before it
  a_no_stall_on_squash: assert property (
    @(posedge clk) disable iff (rst)
    !(prev_stall && next_squash)
  );

endmodule

//--- design/pipe_pkg.sv
// shared widths, opcode enum and the command, stage payload and result structs
package pipe_pkg;

  // --------------------------------------------------
  // widths
  // --------------------------------------------------

  // register and result values
  localparam int DATA_W = 16;
  // register file depth and index width
  localparam int REG_N  = 4;
  localparam int REG_AW = $clog2(REG_N);
  // sequence tag, wraps at 256
  localparam int TAG_W  = 8;
  // raw immediate, zero-extended to DATA_W in decode
  localparam int IMM_W  = 8;

  // --------------------------------------------------
  // opcodes
  // --------------------------------------------------

  typedef enum logic [1:0] {
    OP_ADD  = 2'd0,
    OP_SUB  = 2'd1,
    OP_MUL  = 2'd2,
    // drops the command right behind it, writes nothing
    OP_SKIP = 2'd3
  } op_e;

  // --------------------------------------------------
  // bundles
  // --------------------------------------------------

  // raw command as presented on in_cmd
  typedef struct packed {
    op_e               op;
    logic [REG_AW-1:0] rd;
    logic [REG_AW-1:0] rs;
    logic [IMM_W-1:0]  imm;
  } cmd_t;

  // execute payload, built by decode
  typedef struct packed {
    op_e               op;
    logic [REG_AW-1:0] rd;
    logic [REG_AW-1:0] rs;
    logic [DATA_W-1:0] imm;
    logic [TAG_W-1:0]  tag;
    // low only for SKIP
    logic              writes;
  } dec_t;

  // writeback payload, built by execute
  typedef struct packed {
    logic [REG_AW-1:0] rd;
    logic [DATA_W-1:0] value;
    logic              writes;
    logic [TAG_W-1:0]  tag;
  } wb_t;

  // result on out_data
  typedef struct packed {
    logic [TAG_W-1:0]  tag;
    logic [REG_AW-1:0] rd;
    logic [DATA_W-1:0] value;
  } result_t;

endpackage
